//--- addr_calc.sv
`timescale 1ns/10ps
`include "image_read_config.svh"

module addr_calc (
    input  logic                      clk,
    input  image_read_pkg::walk_pos_t pos_i,
    input  image_read_pkg::geom_t     geom_i,
    output image_read_pkg::mem_req_t  req_o
);

    // stage 1, padded coordinates and padding flag
    logic [`IR_DIM_W-1:0] x_1p;
    logic [`IR_DIM_W-1:0] y_1p;
    logic [`IR_DIM_W-1:0] d_1p;
    logic                 val_1p;
    logic                 pad_1p;
    logic                 last_1p;

    // stage 2, row and column offsets
    logic [`IR_DIM_W-1:0] row_2p;
    logic [`IR_DIM_W-1:0] col_2p;
    logic [`IR_DIM_W-1:0] d_2p;
    logic                 val_2p;
    logic                 pad_2p;
    logic                 last_2p;

    // stage 3, partial sum
    logic [`IR_DIM_W-1:0] sum_3p;
    logic [`IR_DIM_W-1:0] d_3p;
    logic                 rd_3p;
    logic                 pad_3p;
    logic                 last_3p;

    always_ff @(posedge clk) begin
        x_1p    <= pos_i.x;
        y_1p    <= pos_i.y;
        d_1p    <= pos_i.d;
        val_1p  <= pos_i.valid;
        last_1p <= pos_i.last;
        pad_1p  <= pos_i.valid & ((pos_i.x < geom_i.edge_l) | (pos_i.x > geom_i.edge_r)
                                | (pos_i.y < geom_i.edge_t) | (pos_i.y > geom_i.edge_b));
    end

    // multiply here so a following job cannot change img_d under an old position
    always_ff @(posedge clk) begin
        row_2p  <= (y_1p - geom_i.pad_t) * geom_i.plane_wxd;
        col_2p  <= (x_1p - geom_i.pad_l) * geom_i.img_d;
        d_2p    <= d_1p;
        val_2p  <= val_1p;
        pad_2p  <= pad_1p;
        last_2p <= last_1p;
    end

    always_ff @(posedge clk) begin
        sum_3p  <= row_2p + col_2p;
        d_3p    <= d_2p;
        rd_3p   <= val_2p & ~pad_2p;    // padding never reaches the memory
        pad_3p  <= pad_2p;
        last_3p <= last_2p;
    end

    always_ff @(posedge clk) begin
        req_o.addr   <= rd_3p ? (sum_3p + d_3p) : '0;
        req_o.rd_val <= rd_3p;
        req_o.pad    <= pad_3p;
        req_o.last   <= last_3p;
    end

endmodule

//--- build.f
+incdir+.
image_read_pkg.sv
image_cfg_regs.sv
window_walk.sv
addr_calc.sv
read_align.sv
stream_fifo.sv
image_read.sv
tb_image_read.sv

//--- image_cfg_regs.sv
`timescale 1ns/10ps
`include "image_read_config.svh"

module image_cfg_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  image_read_pkg::cfg_wr_t cfg_i,
    input  logic                    start_i,
    output image_read_pkg::geom_t   geom_o,
    output logic                    geom_ok_o
);

    logic [`IR_DIM_W-1:0] cfg_img_w;
    logic [`IR_DIM_W-1:0] cfg_img_h;
    logic [`IR_DIM_W-1:0] cfg_img_d;
    logic [7:0]           cfg_pad_l;
    logic [7:0]           cfg_pad_r;
    logic [7:0]           cfg_pad_t;
    logic [7:0]           cfg_pad_b;
    logic [7:0]           cfg_side;
    logic [`IR_DIM_W-1:0] cfg_step;
    logic                 start_1p;     // offsets applied, derive next

    // raw registers, written whenever the valid bit is high
    always_ff @(posedge clk) begin
        if (cfg_i.valid) begin
            case (cfg_i.addr)
                image_read_pkg::CFG_IMG_W: begin
                    cfg_img_w <= cfg_i.data[15:0];
                end
                image_read_pkg::CFG_IMG_DH: begin
                    cfg_img_d <= cfg_i.data[31:16];
                    cfg_img_h <= cfg_i.data[15:0];
                end
                image_read_pkg::CFG_PAD: begin
                    cfg_pad_l <= cfg_i.data[31:24];
                    cfg_pad_r <= cfg_i.data[23:16];
                    cfg_pad_t <= cfg_i.data[15:8];
                    cfg_pad_b <= cfg_i.data[7:0];
                end
                default: begin
                    cfg_side  <= cfg_i.data[23:16];
                    cfg_step  <= cfg_i.data[15:0];
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            geom_o.img_w <= cfg_img_w + `IR_DIM_W'(1);     // 0 is a single pixel
            geom_o.img_h <= cfg_img_h + `IR_DIM_W'(1);
            geom_o.img_d <= cfg_img_d + `IR_DIM_W'(1);
            geom_o.pad_l <= `IR_DIM_W'(cfg_pad_l);          // 0 is no padding
            geom_o.pad_r <= `IR_DIM_W'(cfg_pad_r);
            geom_o.pad_t <= `IR_DIM_W'(cfg_pad_t);
            geom_o.pad_b <= `IR_DIM_W'(cfg_pad_b);
            geom_o.side  <= `IR_DIM_W'(cfg_side) + `IR_DIM_W'(1);
            geom_o.step  <= cfg_step + `IR_DIM_W'(1);
        end

        // second step works from the values latched above
        if (start_1p) begin
            geom_o.area_w    <= geom_o.pad_l + geom_o.img_w + geom_o.pad_r;
            geom_o.area_h    <= geom_o.pad_t + geom_o.img_h + geom_o.pad_b;
            geom_o.edge_l    <= geom_o.pad_l;
            geom_o.edge_t    <= geom_o.pad_t;
            geom_o.edge_r    <= geom_o.pad_l + geom_o.img_w - `IR_DIM_W'(1);
            geom_o.edge_b    <= geom_o.pad_t + geom_o.img_h - `IR_DIM_W'(1);
            geom_o.plane_wxd <= geom_o.img_w * geom_o.img_d;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            start_1p  <= 1'b0;
            geom_ok_o <= 1'b0;
        end else begin
            start_1p  <= start_i;
            geom_ok_o <= start_1p;      // derived fields land on the same edge
        end
    end

endmodule

//--- image_read.sv
`timescale 1ns/10ps
`include "image_read_config.svh"

module image_read (
    input  logic                    clk,
    input  logic                    rst,
    input  image_read_pkg::cfg_wr_t cfg_i,
    input  logic                    start_i,
    output logic                    ready_o,
    output logic                    rd_val_o,
    output logic [`IR_MEM_AW-1:0]   rd_addr_o,
    input  logic [`IR_BUS_W-1:0]    rd_data_i,
    output logic [`IR_BUS_W-1:0]    img_data_o,
    output logic                    img_last_o,
    output logic                    img_val_o,
    input  logic                    img_rdy_i
);

    image_read_pkg::geom_t     geom;
    image_read_pkg::walk_pos_t pos;
    image_read_pkg::mem_req_t  req;
    logic                      geom_ok;
    logic                      start_ok;    // start seen while idle
    logic                      almost_full;
    logic                      push;
    logic [`IR_BUS_W:0]        push_data;

    // registers only latch when the walker can take the job
    assign start_ok  = start_i & ready_o;
    assign rd_val_o  = req.rd_val;
    assign rd_addr_o = req.addr;

    image_cfg_regs image_cfg_regs_i (
        .clk       (clk),
        .rst       (rst),
        .cfg_i     (cfg_i),
        .start_i   (start_ok),
        .geom_o    (geom),
        .geom_ok_o (geom_ok)
    );

    window_walk window_walk_i (
        .clk       (clk),
        .rst       (rst),
        .start_i   (start_i),
        .geom_i    (geom),
        .geom_ok_i (geom_ok),
        .hold_i    (almost_full),
        .ready_o   (ready_o),
        .pos_o     (pos)
    );

    addr_calc addr_calc_i (
        .clk    (clk),
        .pos_i  (pos),
        .geom_i (geom),
        .req_o  (req)
    );

    read_align read_align_i (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req),
        .rd_data_i   (rd_data_i),
        .push_o      (push),
        .push_data_o (push_data)
    );

    stream_fifo stream_fifo_i (
        .clk           (clk),
        .rst           (rst),
        .push_i        (push),
        .push_data_i   (push_data),
        .almost_full_o (almost_full),
        .data_o        (img_data_o),
        .last_o        (img_last_o),
        .val_o         (img_val_o),
        .rdy_i         (img_rdy_i)
    );

endmodule

//--- image_read_config.svh
`ifndef IMAGE_READ_CONFIG_SVH
`define IMAGE_READ_CONFIG_SVH

// one beat is four 16 bit pixel lanes
`define IR_PIX_W        16
`define IR_LANES        4
`define IR_BUS_W        (`IR_PIX_W * `IR_LANES)

// image memory
`define IR_MEM_AW       16
`define IR_RD_LATENCY   3       // edges from rd_val_o to rd_data_i

// coordinates, counters and every geometry field
`define IR_DIM_W        16

// output buffer is 2**IR_FIFO_AW deep
`define IR_FIFO_AW      4

// fill level where the walk pauses
// 16 entries less the 8 beats that can still be in flight behind it
`define IR_FIFO_SLACK   8

`endif

//--- image_read_pkg.sv
`include "image_read_config.svh"

package image_read_pkg;

    // config register addresses
    typedef enum logic [1:0] {
        CFG_IMG_W  = 2'd0,
        CFG_IMG_DH = 2'd1,
        CFG_PAD    = 2'd2,
        CFG_CONV   = 2'd3
    } cfg_reg_e;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_ACTIVE,
        ST_PAUSE
    } walk_state_e;

    typedef struct packed {
        logic        valid;
        cfg_reg_e    addr;
        logic [31:0] data;
    } cfg_wr_t;

    // job geometry, sizes already hold the plus-one offset
    typedef struct packed {
        logic [`IR_DIM_W-1:0] img_w;
        logic [`IR_DIM_W-1:0] img_h;
        logic [`IR_DIM_W-1:0] img_d;
        logic [`IR_DIM_W-1:0] pad_l;
        logic [`IR_DIM_W-1:0] pad_r;
        logic [`IR_DIM_W-1:0] pad_t;
        logic [`IR_DIM_W-1:0] pad_b;
        logic [`IR_DIM_W-1:0] side;         // window side
        logic [`IR_DIM_W-1:0] step;         // distance between window starts
        logic [`IR_DIM_W-1:0] area_w;       // image plus padding
        logic [`IR_DIM_W-1:0] area_h;
        logic [`IR_DIM_W-1:0] edge_l;       // first image column in the area
        logic [`IR_DIM_W-1:0] edge_r;       // last image column in the area
        logic [`IR_DIM_W-1:0] edge_t;
        logic [`IR_DIM_W-1:0] edge_b;
        logic [`IR_DIM_W-1:0] plane_wxd;    // words per image row
    } geom_t;

    // one padded coordinate out of the walker
    typedef struct packed {
        logic [`IR_DIM_W-1:0] x;
        logic [`IR_DIM_W-1:0] y;
        logic [`IR_DIM_W-1:0] d;
        logic                 valid;
        logic                 last;
    } walk_pos_t;

    typedef struct packed {
        logic [`IR_MEM_AW-1:0] addr;
        logic                  rd_val;  // real memory read
        logic                  pad;     // zero beat, no read
        logic                  last;
    } mem_req_t;

endpackage

//--- read_align.sv
`timescale 1ns/10ps
`include "image_read_config.svh"

module read_align (
    input  logic                     clk,
    input  logic                     rst,
    input  image_read_pkg::mem_req_t req_i,
    input  logic [`IR_BUS_W-1:0]     rd_data_i,
    output logic                     push_o,
    output logic [`IR_BUS_W:0]       push_data_o    // beat on top, last in bit 0
);

    logic [`IR_RD_LATENCY-1:0] rd_sr;
    logic [`IR_RD_LATENCY-1:0] pad_sr;
    logic [`IR_RD_LATENCY-1:0] last_sr;
    logic                      rd_arr;      // memory word is on rd_data_i now
    logic                      pad_arr;
    logic                      last_arr;

    assign rd_arr   = rd_sr[`IR_RD_LATENCY-1];
    assign pad_arr  = pad_sr[`IR_RD_LATENCY-1];
    assign last_arr = last_sr[`IR_RD_LATENCY-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_sr  <= '0;
            pad_sr <= '0;
            push_o <= 1'b0;
        end else begin
            rd_sr  <= {rd_sr[`IR_RD_LATENCY-2:0], req_i.rd_val};
            pad_sr <= {pad_sr[`IR_RD_LATENCY-2:0], req_i.pad};
            push_o <= rd_arr | pad_arr;         // one beat per request
        end
    end

    always_ff @(posedge clk) begin
        last_sr     <= {last_sr[`IR_RD_LATENCY-2:0], req_i.last};
        push_data_o <= {(rd_arr ? rd_data_i : {`IR_BUS_W{1'b0}}), last_arr};
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f build.f --top-module tb_image_read -o tb_image_read \
    && ./obj_dir/tb_image_read | tee /dev/stderr | grep -x "TEST RESULT: PASS" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- stream_fifo.sv
`timescale 1ns/10ps
`include "image_read_config.svh"

module stream_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push_i,
    input  logic [`IR_BUS_W:0]   push_data_i,
    output logic                 almost_full_o,
    output logic [`IR_BUS_W-1:0] data_o,
    output logic                 last_o,
    output logic                 val_o,
    input  logic                 rdy_i
);

    logic [`IR_BUS_W:0]     mem [0:(1 << `IR_FIFO_AW)-1];
    logic [`IR_FIFO_AW-1:0] wr_ptr;
    logic [`IR_FIFO_AW-1:0] rd_ptr;
    logic [`IR_FIFO_AW:0]   count;      // ram entries only, output reg not counted
    logic [`IR_BUS_W:0]     out_q;
    logic                   pop;

    // refill the output register when it is empty or being taken
    assign pop           = (count != '0) & (~val_o | rdy_i);
    assign almost_full_o = (count >= (`IR_FIFO_AW+1)'(`IR_FIFO_SLACK));

    always_ff @(posedge clk) begin
        if (push_i) mem[wr_ptr] <= push_data_i;
        if (pop) out_q <= mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            val_o  <= 1'b0;
        end else begin
            if (push_i) wr_ptr <= wr_ptr + `IR_FIFO_AW'(1);
            if (pop) rd_ptr <= rd_ptr + `IR_FIFO_AW'(1);
            case ({push_i, pop})
                2'b10:   count <= count + (`IR_FIFO_AW+1)'(1);
                2'b01:   count <= count - (`IR_FIFO_AW+1)'(1);
                default: count <= count;
            endcase
            if (pop) begin
                val_o <= 1'b1;
            end else if (rdy_i) begin
                val_o <= 1'b0;          // beat taken, nothing behind it
            end
        end
    end

    assign data_o = out_q[`IR_BUS_W:1];
    assign last_o = val_o & out_q[0];

endmodule

//--- tb_image_read.sv
`timescale 1ns/10ps
`include "image_read_config.svh"

module tb_image_read;

    localparam int TIMEOUT_CYC = 4000;

    logic                    clk = 1'b0;
    logic                    rst;
    image_read_pkg::cfg_wr_t cfg_wr;
    logic                    start;
    logic                    ready;
    logic                    rd_val;
    logic [`IR_MEM_AW-1:0]   rd_addr;
    logic [`IR_BUS_W-1:0]    rd_data;
    logic [`IR_BUS_W-1:0]    img_data;
    logic                    img_last;
    logic                    img_val;
    logic                    img_rdy;

    logic [`IR_BUS_W-1:0]    rd_pipe [0:`IR_RD_LATENCY-1];   // memory read latency
    logic [`IR_BUS_W-1:0]    exp_data[$];
    logic                    exp_last[$];
    logic [`IR_MEM_AW-1:0]   exp_addr[$];
    int                      job_beats[$];      // beat count of each finished job
    int                      errors = 0;
    int                      checks = 0;
    int                      beats = 0;
    int                      beats_in_job = 0;
    int                      lasts_seen = 0;
    logic                    rand_rdy = 1'b0;
    logic                    stalled = 1'b0;
    logic [`IR_BUS_W-1:0]    held_data;
    logic                    held_last;

    always #4 clk = ~clk;

    image_read image_read_i (
        .clk        (clk),
        .rst        (rst),
        .cfg_i      (cfg_wr),
        .start_i    (start),
        .ready_o    (ready),
        .rd_val_o   (rd_val),
        .rd_addr_o  (rd_addr),
        .rd_data_i  (rd_data),
        .img_data_o (img_data),
        .img_last_o (img_last),
        .img_val_o  (img_val),
        .img_rdy_i  (img_rdy)
    );

    // word a holds a*4+k in lane k
    function automatic logic [`IR_BUS_W-1:0] mem_word(input int a);
        logic [`IR_BUS_W-1:0] w;
        for (int k = 0; k < `IR_LANES; k++) begin
            w[k*`IR_PIX_W +: `IR_PIX_W] = `IR_PIX_W'(a * 4 + k);
        end
        return w;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `IR_RD_LATENCY; i++) begin
                rd_pipe[i] <= '0;
            end
        end else begin
            rd_pipe[0] <= rd_val ? mem_word(int'(rd_addr)) : '0;
            for (int i = 1; i < `IR_RD_LATENCY; i++) begin
                rd_pipe[i] <= rd_pipe[i-1];
            end
        end
    end

    assign rd_data = rd_pipe[`IR_RD_LATENCY-1];

    // appends the expected beats and read addresses of one job behind earlier jobs
    function automatic int build_expected(input logic [31:0] r_w, r_dh, r_pad, r_conv);
        int w, h, d, pl, pr, pt, pb, side, step, aw, ah, x, y, a, n;
        w    = int'(r_w[15:0]) + 1;
        h    = int'(r_dh[15:0]) + 1;
        d    = int'(r_dh[31:16]) + 1;
        pl   = int'(r_pad[31:24]);
        pr   = int'(r_pad[23:16]);
        pt   = int'(r_pad[15:8]);
        pb   = int'(r_pad[7:0]);
        side = int'(r_conv[23:16]) + 1;
        step = int'(r_conv[15:0]) + 1;
        aw   = pl + w + pr;
        ah   = pt + h + pb;
        n    = 0;
        for (int sy = 0; sy <= ah - side; sy += step) begin
            for (int sx = 0; sx <= aw - side; sx += step) begin
                for (int wy = 0; wy < side; wy++) begin
                    for (int wx = 0; wx < side; wx++) begin
                        for (int dd = 0; dd < d; dd++) begin
                            x = sx + wx;
                            y = sy + wy;
                            if (x < pl || x >= pl + w || y < pt || y >= pt + h) begin
                                exp_data.push_back('0);     // padding pixel
                            end else begin
                                a = (y - pt) * w * d + (x - pl) * d + dd;
                                exp_data.push_back(mem_word(a));
                                exp_addr.push_back(`IR_MEM_AW'(a));
                            end
                            exp_last.push_back(1'b0);
                            n++;
                        end
                    end
                end
            end
        end
        exp_last[exp_last.size()-1] = 1'b1;
        return n;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expv);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, got, expv);
        end
    endtask

    task automatic finish_run;
        $display("checks %0d, errors %0d, beats %0d", checks, errors, beats);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic wait_lasts(input int target, output logic done);
        int n;
        n = 0;
        while (lasts_seen < target && n < TIMEOUT_CYC) begin
            @(negedge clk);
            n++;
        end
        done = (lasts_seen >= target);
        if (!done) begin
            errors++;
            $display("timeout: job %0d never delivered its last beat", target);
        end
    endtask

    task automatic write_reg(input image_read_pkg::cfg_reg_e a, input logic [31:0] d);
        @(posedge clk);
        cfg_wr.valid <= 1'b1;
        cfg_wr.addr  <= a;
        cfg_wr.data  <= d;
    endtask

    task automatic load_job(input logic [31:0] r_w, r_dh, r_pad, r_conv, output int n);
        write_reg(image_read_pkg::CFG_IMG_W, r_w);
        write_reg(image_read_pkg::CFG_IMG_DH, r_dh);
        write_reg(image_read_pkg::CFG_PAD, r_pad);
        write_reg(image_read_pkg::CFG_CONV, r_conv);
        @(posedge clk);
        cfg_wr.valid <= 1'b0;
        n = build_expected(r_w, r_dh, r_pad, r_conv);
        @(negedge clk);
    endtask

    task automatic pulse_start;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
    endtask

    task automatic finish_job(input int n, input int target);
        logic done;
        wait_lasts(target, done);
        if (done) begin
            check_value("beats in job", 64'(job_beats.pop_front()), 64'(n));
            check_value("ready_o after last beat", 64'(ready), 64'd1);
        end
    endtask

    always @(posedge clk) begin
        if (rand_rdy) begin
            img_rdy <= ($urandom_range(99) >= 40);  // low about 40% of cycles
        end else begin
            img_rdy <= 1'b1;
        end
    end

    // receiver compares at the falling edge where the stream is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (stalled) begin
                check_value("img_val_o while stalled", 64'(img_val), 64'd1);
                check_value("img_data_o while stalled", img_data, held_data);
                check_value("img_last_o while stalled", 64'(img_last), 64'(held_last));
            end
            if (img_val && img_rdy) begin
                if (exp_data.size() == 0) begin
                    errors++;
                    $display("beat at %0t arrived with no reference entry left", $time);
                end else begin
                    check_value("img_data_o", img_data, exp_data.pop_front());
                    check_value("img_last_o", 64'(img_last), 64'(exp_last.pop_front()));
                end
                beats++;
                beats_in_job++;
                if (img_last) begin
                    job_beats.push_back(beats_in_job);
                    beats_in_job = 0;
                    lasts_seen++;
                end
            end
            stalled   = img_val && !img_rdy;
            held_data = img_data;
            held_last = img_last;
        end
    end

    always @(negedge clk) begin
        if (!rst && rd_val) begin
            if (exp_addr.size() == 0) begin
                errors++;
                $display("memory read at %0t with no read left in the reference", $time);
            end else begin
                check_value("rd_addr_o", 64'(rd_addr), 64'(exp_addr.pop_front()));
            end
        end
    end

    initial begin
        int n1;
        int n2;
        void'($urandom(32'hf391cccc));
        rst     = 1'b1;
        cfg_wr  = '0;
        start   = 1'b0;
        img_rdy = 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("ready_o after reset", 64'(ready), 64'd1);
        check_value("img_val_o after reset", 64'(img_val), 64'd0);
        check_value("rd_val_o after reset", 64'(rd_val), 64'd0);

        // 4x4x1, 1x1 window, step 1, no padding
        load_job(32'd3, 32'h0000_0003, 32'h0000_0000, 32'h0000_0000, n1);
        check_value("reference beats 4x4", 64'(n1), 64'd16);
        pulse_start;
        check_value("ready_o after start", 64'(ready), 64'd0);
        finish_job(n1, 1);

        // 3x3 window with one pixel of padding on every side
        load_job(32'd3, 32'h0000_0003, 32'h0101_0101, 32'h0002_0000, n1);
        pulse_start;
        check_value("ready_o after start", 64'(ready), 64'd0);
        finish_job(n1, 2);

        // 5x4x3 image, 2x2 window, step 2, left pad 2
        load_job(32'd4, 32'h0002_0003, 32'h0200_0000, 32'h0001_0001, n1);
        pulse_start;
        finish_job(n1, 3);

        // same padded job under random back pressure
        rand_rdy = 1'b1;
        load_job(32'd3, 32'h0000_0003, 32'h0101_0101, 32'h0002_0000, n1);
        pulse_start;
        finish_job(n1, 4);

        // second config written while the first job runs and an extra start that is ignored
        load_job(32'd4, 32'h0002_0003, 32'h0200_0000, 32'h0001_0001, n1);
        pulse_start;
        load_job(32'd2, 32'h0001_0001, 32'h0100_0100, 32'h0001_0000, n2);
        check_value("ready_o before busy start", 64'(ready), 64'd0);
        pulse_start;
        finish_job(n1, 5);
        repeat (30) begin
            @(negedge clk);
            check_value("img_val_o between jobs", 64'(img_val), 64'd0);
            check_value("ready_o between jobs", 64'(ready), 64'd1);
        end
        pulse_start;
        finish_job(n2, 6);
        check_value("reference entries left", 64'(exp_data.size()), 64'd0);
        check_value("reference reads left", 64'(exp_addr.size()), 64'd0);
        finish_run;
    end

endmodule

//--- window_walk.sv
`timescale 1ns/10ps
`include "image_read_config.svh"

module window_walk (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start_i,
    input  image_read_pkg::geom_t     geom_i,
    input  logic                      geom_ok_i,
    input  logic                      hold_i,       // buffer almost full
    output logic                      ready_o,
    output image_read_pkg::walk_pos_t pos_o
);

    image_read_pkg::walk_state_e state;
    image_read_pkg::walk_state_e state_nx;

    logic [`IR_DIM_W-1:0] area_x;       // window start column
    logic [`IR_DIM_W-1:0] area_y;       // window start row
    logic [`IR_DIM_W-1:0] win_x;        // offset inside the window
    logic [`IR_DIM_W-1:0] win_y;
    logic [`IR_DIM_W-1:0] dep;
    logic [`IR_DIM_W:0]   area_x_nx;    // one extra bit so the compare cannot wrap
    logic [`IR_DIM_W:0]   area_y_nx;
    logic [`IR_DIM_W:0]   room_w;       // last legal window start
    logic [`IR_DIM_W:0]   room_h;
    logic                 d_last;
    logic                 wx_last;
    logic                 wy_last;
    logic                 ax_last;
    logic                 ay_last;
    logic                 walk_end;
    logic                 advance;

    assign room_w    = {1'b0, geom_i.area_w - geom_i.side};
    assign room_h    = {1'b0, geom_i.area_h - geom_i.side};
    assign area_x_nx = {1'b0, area_x} + {1'b0, geom_i.step};
    assign area_y_nx = {1'b0, area_y} + {1'b0, geom_i.step};

    assign d_last   = (dep == geom_i.img_d - `IR_DIM_W'(1));
    assign wx_last  = (win_x == geom_i.side - `IR_DIM_W'(1));
    assign wy_last  = (win_y == geom_i.side - `IR_DIM_W'(1));
    assign ax_last  = (area_x_nx > room_w);
    assign ay_last  = (area_y_nx > room_h);
    assign walk_end = d_last & wx_last & wy_last & ax_last & ay_last;

    // hold stops emission in the same cycle, which keeps in-flight beats at 8
    assign advance = (state == image_read_pkg::ST_ACTIVE) & ~hold_i;
    assign ready_o = (state == image_read_pkg::ST_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= image_read_pkg::ST_IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            image_read_pkg::ST_IDLE: begin
                if (start_i) state_nx = image_read_pkg::ST_LOAD;
            end
            image_read_pkg::ST_LOAD: begin
                if (geom_ok_i) state_nx = image_read_pkg::ST_ACTIVE;
            end
            image_read_pkg::ST_ACTIVE: begin
                if (advance & walk_end) begin
                    state_nx = image_read_pkg::ST_IDLE;
                end else if (hold_i) begin
                    state_nx = image_read_pkg::ST_PAUSE;
                end
            end
            default: begin
                if (!hold_i) state_nx = image_read_pkg::ST_ACTIVE;
            end
        endcase
    end

    // depth innermost, then window column, window row, start column, start row
    always_ff @(posedge clk) begin
        if (rst || state == image_read_pkg::ST_IDLE) begin
            area_x <= '0;
            area_y <= '0;
            win_x  <= '0;
            win_y  <= '0;
            dep    <= '0;
        end else if (advance) begin
            dep <= dep + `IR_DIM_W'(1);
            if (d_last) begin
                dep   <= '0;
                win_x <= win_x + `IR_DIM_W'(1);
                if (wx_last) begin
                    win_x <= '0;
                    win_y <= win_y + `IR_DIM_W'(1);
                    if (wy_last) begin
                        win_y  <= '0;
                        area_x <= area_x_nx[`IR_DIM_W-1:0];
                        if (ax_last) begin
                            area_x <= '0;
                            area_y <= ay_last ? '0 : area_y_nx[`IR_DIM_W-1:0];
                        end
                    end
                end
            end
        end
    end

    always_comb begin
        pos_o.x     = area_x + win_x;
        pos_o.y     = area_y + win_y;
        pos_o.d     = dep;
        pos_o.valid = advance;
        pos_o.last  = advance & walk_end;
    end

endmodule
